//--- list.f
+incdir+common
common/raster_pkg.sv
common/frag_if.sv
rtl/frame_ctrl.sv
raster/rect_raster.sv
fb/frame_buffer.sv
rtl/render_top.sv
dv/render_asserts.sv
dv/render_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the frame engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module render_tb \
    --Mdir obj_dir -o render_sim \
    -f list.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/render_sim 2>&1)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- dv/render_tb.sv
`timescale 1ns/1ps
`include "raster_cfg.svh"

module render_tb import raster_pkg::*; ();

    localparam int SCREEN_W    = `RASTER_SCREEN_W;
    localparam int SCREEN_H    = `RASTER_SCREEN_H;
    localparam int PIX_N       = SCREEN_W * SCREEN_H;
    localparam int N_FRAMES    = 7;
    localparam int MAX_OBJS    = 4;
    localparam int OBJ_TIMEOUT = 1000;
    localparam int END_TIMEOUT = 1000;

    logic                       clk_100m;
    logic                       i_rst;
    logic                       i_frame_start;
    logic [`RASTER_COUNT_W-1:0] i_num_objects;
    logic                       i_obj_valid;
    logic [`RASTER_COORD_W-1:0] i_obj_x0;
    logic [`RASTER_COORD_W-1:0] i_obj_y0;
    logic [`RASTER_COORD_W-1:0] i_obj_x1;
    logic [`RASTER_COORD_W-1:0] i_obj_y1;
    logic [`RASTER_DEPTH_W-1:0] i_obj_depth;
    logic [`RASTER_COLOR_W-1:0] i_obj_color;
    logic [`RASTER_ADDR_W-1:0]  i_rd_addr;
    logic                       o_obj_ready;
    logic                       o_frame_done;
    logic                       o_busy;
    logic [`RASTER_COLOR_W-1:0] o_rd_color;
    logic [`RASTER_DEPTH_W-1:0] o_rd_depth;

    // stimulus table, one row per frame
    int        tbl_count [N_FRAMES];
    rect_obj_t tbl_obj   [N_FRAMES][MAX_OBJS];

    // reference framebuffer
    logic [`RASTER_COLOR_W-1:0] ref_color [PIX_N];
    logic [`RASTER_DEPTH_W-1:0] ref_depth [PIX_N];

    logic [31:0] rng_state = 32'h0c75c4c5;

    render_top u_dut (
        .clk_100m      (clk_100m),
        .i_rst         (i_rst),
        .i_frame_start (i_frame_start),
        .i_num_objects (i_num_objects),
        .i_obj_valid   (i_obj_valid),
        .i_obj_x0      (i_obj_x0),
        .i_obj_y0      (i_obj_y0),
        .i_obj_x1      (i_obj_x1),
        .i_obj_y1      (i_obj_y1),
        .i_obj_depth   (i_obj_depth),
        .i_obj_color   (i_obj_color),
        .i_rd_addr     (i_rd_addr),
        .o_obj_ready   (o_obj_ready),
        .o_frame_done  (o_frame_done),
        .o_busy        (o_busy),
        .o_rd_color    (o_rd_color),
        .o_rd_depth    (o_rd_depth)
    );

    // 100 MHz
    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            fail_run($sformatf("error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
        end
    endtask

    // lcg, numerical recipes constants
    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic set_rect(input int f, input int k, input int x0, input int y0,
                            input int x1, input int y1, input int depth, input int color);
        tbl_obj[f][k].x0    = `RASTER_COORD_W'(x0);
        tbl_obj[f][k].y0    = `RASTER_COORD_W'(y0);
        tbl_obj[f][k].x1    = `RASTER_COORD_W'(x1);
        tbl_obj[f][k].y1    = `RASTER_COORD_W'(y1);
        tbl_obj[f][k].depth = `RASTER_DEPTH_W'(depth);
        tbl_obj[f][k].color = `RASTER_COLOR_W'(color);
    endtask

    // legal random rectangles, 1 to 4 per frame
    task automatic fill_random_frame(input int f);
        logic [31:0] r;
        int x0;
        int y0;
        int x1;
        int y1;
        tbl_count[f] = 1 + int'(next_rand() % 32'd4);
        for (int k = 0; k < MAX_OBJS; k++) begin
            r  = next_rand();
            x0 = int'(r[31:24]) % SCREEN_W;
            x1 = x0 + int'(r[23:16]) % (SCREEN_W - x0);
            r  = next_rand();
            y0 = int'(r[31:24]) % SCREEN_H;
            y1 = y0 + int'(r[23:16]) % (SCREEN_H - y0);
            r  = next_rand();
            set_rect(f, k, x0, y0, x1, y1, int'(r[31:20]), int'(r[19:16]));
        end
    endtask

    task automatic build_table();
        // empty frame, clear only
        tbl_count[0] = 0;
        // single rectangle
        tbl_count[1] = 1;
        set_rect(1, 0, 2, 3, 6, 5, 100, 5);
        // far, then nearer on top, then farther under, then equal depth
        tbl_count[2] = 4;
        set_rect(2, 0, 0, 0, 7, 7, 500, 3);
        set_rect(2, 1, 4, 4, 11, 9, 200, 9);
        set_rect(2, 2, 2, 2, 5, 5, 800, 1);
        set_rect(2, 3, 10, 8, 13, 10, 200, 12);
        // corners, a full row and a full column, back to back
        tbl_count[3] = 4;
        set_rect(3, 0, 0, 0, 0, 0, 10, 2);
        set_rect(3, 1, 15, 11, 15, 11, 20, 4);
        set_rect(3, 2, 0, 6, 15, 6, 300, 6);
        set_rect(3, 3, 8, 0, 8, 11, 250, 7);
        // empty again, must come back cleared
        tbl_count[4] = 0;
        fill_random_frame(5);
        fill_random_frame(6);
    endtask

    task automatic ref_clear();
        for (int a = 0; a < PIX_N; a++) begin
            ref_color[a] = '0;
            ref_depth[a] = '1;
        end
    endtask

    // strictly nearer fragment replaces the stored one
    task automatic ref_draw(input rect_obj_t obj);
        int addr;
        for (int y = int'(obj.y0); y <= int'(obj.y1); y++) begin
            for (int x = int'(obj.x0); x <= int'(obj.x1); x++) begin
                addr = y * SCREEN_W + x;
                if (obj.depth < ref_depth[addr]) begin
                    ref_color[addr] = obj.color;
                    ref_depth[addr] = obj.depth;
                end
            end
        end
    endtask

    task automatic drive_obj(input rect_obj_t obj);
        i_obj_valid = 1'b1;
        i_obj_x0    = obj.x0;
        i_obj_y0    = obj.y0;
        i_obj_x1    = obj.x1;
        i_obj_y1    = obj.y1;
        i_obj_depth = obj.depth;
        i_obj_color = obj.color;
    endtask

    task automatic run_frame(input int f);
        int n;
        int wait_cnt;
        n = tbl_count[f];
        @(negedge clk_100m);
        check_value(32'(o_obj_ready), 32'd0, "o_obj_ready outside a frame");
        check_value(32'(o_busy), 32'd0, "o_busy before frame start");
        i_frame_start = 1'b1;
        i_num_objects = `RASTER_COUNT_W'(n);
        @(negedge clk_100m);
        i_frame_start = 1'b0;
        check_value(32'(o_busy), 32'd1, "o_busy after frame start");
        ref_clear();
        for (int k = 0; k < n; k++) begin
            // next object offered right after the previous transfer
            drive_obj(tbl_obj[f][k]);
            wait_cnt = 0;
            while (!o_obj_ready) begin
                check_value(32'(o_frame_done), 32'd0, "o_frame_done before all objects");
                @(negedge clk_100m);
                wait_cnt++;
                if (wait_cnt > OBJ_TIMEOUT) begin
                    fail_run($sformatf("timeout waiting for o_obj_ready, frame %0d", f));
                end
            end
            // transfer on the rising edge in between
            @(negedge clk_100m);
            ref_draw(tbl_obj[f][k]);
            check_value(32'(o_obj_ready), 32'd0, "o_obj_ready while raster busy");
        end
        i_obj_valid = 1'b0;
        wait_cnt = 0;
        while (!o_frame_done) begin
            check_value(32'(o_obj_ready), 32'd0, "o_obj_ready after counted objects");
            @(negedge clk_100m);
            wait_cnt++;
            if (wait_cnt > END_TIMEOUT) begin
                fail_run($sformatf("timeout waiting for o_frame_done, frame %0d", f));
            end
        end
        @(negedge clk_100m);
        check_value(32'(o_frame_done), 32'd0, "o_frame_done pulse length");
        check_value(32'(o_busy), 32'd0, "o_busy after frame done");
    endtask

    // registered read port, result one edge later
    task automatic readback_frame(input int f);
        for (int a = 0; a < PIX_N; a++) begin
            i_rd_addr = `RASTER_ADDR_W'(a);
            @(negedge clk_100m);
            check_value(32'(o_rd_color), 32'(ref_color[a]),
                        $sformatf("frame %0d colour at pixel %0d", f, a));
            check_value(32'(o_rd_depth), 32'(ref_depth[a]),
                        $sformatf("frame %0d depth at pixel %0d", f, a));
        end
    endtask

    initial begin
        i_rst         = 1'b1;
        i_frame_start = 1'b0;
        i_num_objects = '0;
        i_obj_valid   = 1'b0;
        i_obj_x0      = '0;
        i_obj_y0      = '0;
        i_obj_x1      = '0;
        i_obj_y1      = '0;
        i_obj_depth   = '0;
        i_obj_color   = '0;
        i_rd_addr     = '0;
        build_table();
        // four rising edges in reset
        repeat (4) @(negedge clk_100m);
        i_rst = 1'b0;
        check_value(32'(o_frame_done), 32'd0, "o_frame_done after reset");
        check_value(32'(o_obj_ready), 32'd0, "o_obj_ready after reset");
        check_value(32'(o_busy), 32'd0, "o_busy after reset");
        for (int f = 0; f < N_FRAMES; f++) begin
            run_frame(f);
            readback_frame(f);
            $display("frame %0d with %0d objects matched", f, tbl_count[f]);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

//--- dv/render_asserts.sv
`timescale 1ns/1ps
`include "raster_cfg.svh"

module render_asserts (
    input logic                       clk_100m,
    input logic                       i_rst,
    input logic                       i_obj_valid,
    input logic                       o_obj_ready,
    input logic [`RASTER_COORD_W-1:0] i_obj_x0,
    input logic [`RASTER_COORD_W-1:0] i_obj_y0,
    input logic [`RASTER_COORD_W-1:0] i_obj_x1,
    input logic [`RASTER_COORD_W-1:0] i_obj_y1,
    input logic [`RASTER_DEPTH_W-1:0] i_obj_depth,
    input logic [`RASTER_COLOR_W-1:0] i_obj_color,
    input logic                       o_frame_done,
    input logic                       frag_valid,
    input logic                       frag_ready,
    input logic [`RASTER_ADDR_W-1:0]  frag_addr,
    input logic [`RASTER_DEPTH_W-1:0] frag_depth,
    input logic [`RASTER_COLOR_W-1:0] frag_color
);

    // fragment stays valid with the same payload until taken
    a_frag_hold: assert property (@(posedge clk_100m) disable iff (i_rst)
        (frag_valid && !frag_ready) |=> (frag_valid && $stable(frag_addr)
            && $stable(frag_depth) && $stable(frag_color)))
        else $error("fragment dropped or changed before ready");

    // offered object held while stalled
    a_obj_hold: assert property (@(posedge clk_100m) disable iff (i_rst)
        (i_obj_valid && !o_obj_ready) |=> (i_obj_valid && $stable(i_obj_x0)
            && $stable(i_obj_y0) && $stable(i_obj_x1) && $stable(i_obj_y1)
            && $stable(i_obj_depth) && $stable(i_obj_color)))
        else $error("object withdrawn or changed before ready");

    // accepted rectangles lie on screen with ordered corners
    a_obj_legal: assert property (@(posedge clk_100m) disable iff (i_rst)
        (i_obj_valid && o_obj_ready) |-> ((i_obj_x0 <= i_obj_x1) && (i_obj_y0 <= i_obj_y1)
            && (32'(i_obj_y1) < `RASTER_SCREEN_H)))
        else $error("illegal rectangle accepted");

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk_100m) disable iff (i_rst)
        o_frame_done |=> !o_frame_done)
        else $error("o_frame_done high for more than one cycle");

endmodule

bind render_top render_asserts u_render_asserts (
    .clk_100m     (clk_100m),
    .i_rst        (i_rst),
    .i_obj_valid  (i_obj_valid),
    .o_obj_ready  (o_obj_ready),
    .i_obj_x0     (i_obj_x0),
    .i_obj_y0     (i_obj_y0),
    .i_obj_x1     (i_obj_x1),
    .i_obj_y1     (i_obj_y1),
    .i_obj_depth  (i_obj_depth),
    .i_obj_color  (i_obj_color),
    .o_frame_done (o_frame_done),
    .frag_valid   (frag_bus.valid),
    .frag_ready   (frag_bus.ready),
    .frag_addr    (frag_bus.addr),
    .frag_depth   (frag_bus.depth),
    .frag_color   (frag_bus.color)
);

//--- rtl/render_top.sv
`timescale 1ns/1ps
`include "raster_cfg.svh"

module render_top import raster_pkg::*; (
    input  logic                       clk_100m,
    input  logic                       i_rst,
    input  logic                       i_frame_start,
    input  logic [`RASTER_COUNT_W-1:0] i_num_objects,
    input  logic                       i_obj_valid,
    input  logic [`RASTER_COORD_W-1:0] i_obj_x0,
    input  logic [`RASTER_COORD_W-1:0] i_obj_y0,
    input  logic [`RASTER_COORD_W-1:0] i_obj_x1,
    input  logic [`RASTER_COORD_W-1:0] i_obj_y1,
    input  logic [`RASTER_DEPTH_W-1:0] i_obj_depth,
    input  logic [`RASTER_COLOR_W-1:0] i_obj_color,
    input  logic [`RASTER_ADDR_W-1:0]  i_rd_addr,
    output logic                       o_obj_ready,
    output logic                       o_frame_done,
    output logic                       o_busy,
    output logic [`RASTER_COLOR_W-1:0] o_rd_color,
    output logic [`RASTER_DEPTH_W-1:0] o_rd_depth
);

    rect_obj_t obj_in;
    rect_obj_t raster_obj;
    logic      raster_valid;
    logic      raster_ready;
    logic      clear_start;
    logic      clear_done;

    // raster to framebuffer fragments
    frag_if frag_bus ();

    // flat object fields into one struct
    assign obj_in = '{
        x0:    i_obj_x0,
        y0:    i_obj_y0,
        x1:    i_obj_x1,
        y1:    i_obj_y1,
        depth: i_obj_depth,
        color: i_obj_color
    };

    frame_ctrl u_frame_ctrl (
        .clk_100m       (clk_100m),
        .i_rst          (i_rst),
        .i_frame_start  (i_frame_start),
        .i_num_objects  (i_num_objects),
        .i_obj_valid    (i_obj_valid),
        .i_obj          (obj_in),
        .i_raster_ready (raster_ready),
        .i_clear_done   (clear_done),
        .o_obj_ready    (o_obj_ready),
        .o_raster_valid (raster_valid),
        .o_raster_obj   (raster_obj),
        .o_clear_start  (clear_start),
        .o_frame_done   (o_frame_done),
        .o_busy         (o_busy)
    );

    rect_raster u_rect_raster (
        .clk_100m    (clk_100m),
        .i_rst       (i_rst),
        .i_obj_valid (raster_valid),
        .i_obj       (raster_obj),
        .o_obj_ready (raster_ready),
        .frag        (frag_bus.producer)
    );

    frame_buffer u_frame_buffer (
        .clk_100m      (clk_100m),
        .i_rst         (i_rst),
        .i_clear_start (clear_start),
        .i_rd_addr     (i_rd_addr),
        .o_clear_done  (clear_done),
        .o_rd_color    (o_rd_color),
        .o_rd_depth    (o_rd_depth),
        .frag          (frag_bus.consumer)
    );

endmodule

//--- fb/frame_buffer.sv
`timescale 1ns/1ps
`include "raster_cfg.svh"

module frame_buffer (
    input  logic                       clk_100m,
    input  logic                       i_rst,
    input  logic                       i_clear_start,
    input  logic [`RASTER_ADDR_W-1:0]  i_rd_addr,
    output logic                       o_clear_done,
    output logic [`RASTER_COLOR_W-1:0] o_rd_color,
    output logic [`RASTER_DEPTH_W-1:0] o_rd_depth,
    frag_if.consumer                   frag
);

    localparam int ADDR_W = `RASTER_ADDR_W;
    localparam int PIX_N  = `RASTER_SCREEN_W * `RASTER_SCREEN_H;

    // colour and depth planes
    logic [`RASTER_COLOR_W-1:0] color_mem [PIX_N];
    logic [`RASTER_DEPTH_W-1:0] depth_mem [PIX_N];

    // clear sweep
    logic              clr_active_q;
    logic [ADDR_W-1:0] clr_addr_q;
    logic              clr_last;

    logic frag_fire;
    logic depth_pass;

    assign clr_last = (clr_addr_q == ADDR_W'(PIX_N - 1));

    // stalls fragments only while sweeping
    assign frag.ready = !clr_active_q;
    assign frag_fire  = frag.valid && frag.ready;

    // strictly nearer wins, equal depth keeps the old pixel
    assign depth_pass = (frag.depth < depth_mem[frag.addr]);

    always_ff @(posedge clk_100m) begin
        if (i_rst) begin
            clr_active_q <= 1'b0;
            clr_addr_q   <= '0;
            o_clear_done <= 1'b0;
        end else begin
            o_clear_done <= 1'b0;
            if (i_clear_start) begin
                clr_active_q <= 1'b1;
                clr_addr_q   <= '0;
            end else if (clr_active_q) begin
                clr_addr_q <= clr_addr_q + ADDR_W'(1);
                // done pulses the cycle after the last address
                if (clr_last) begin
                    clr_active_q <= 1'b0;
                    o_clear_done <= 1'b1;
                end
            end
        end
    end

    // single write port shared by sweep and fragments
    always_ff @(posedge clk_100m) begin
        if (clr_active_q) begin
            // cleared pixel: colour 0, farthest depth
            color_mem[clr_addr_q] <= '0;
            depth_mem[clr_addr_q] <= '1;
        end else if (frag_fire && depth_pass) begin
            color_mem[frag.addr] <= frag.color;
            depth_mem[frag.addr] <= frag.depth;
        end
    end

    // display stand-in
    // one cycle latency
    always_ff @(posedge clk_100m) begin
        o_rd_color <= color_mem[i_rd_addr];
        o_rd_depth <= depth_mem[i_rd_addr];
    end

endmodule

//--- raster/rect_raster.sv
`timescale 1ns/1ps
`include "raster_cfg.svh"

module rect_raster import raster_pkg::*; (
    input  logic      clk_100m,
    input  logic      i_rst,
    input  logic      i_obj_valid,
    input  rect_obj_t i_obj,
    output logic      o_obj_ready,
    frag_if.producer  frag
);

    localparam int ADDR_W = `RASTER_ADDR_W;

    typedef enum logic {
        RAST_IDLE,
        RAST_EMIT
    } rast_state_t;

    rast_state_t state_q;

    // current pixel
    logic [`RASTER_COORD_W-1:0] x_q;
    logic [`RASTER_COORD_W-1:0] y_q;

    // latched rectangle, y0 only needed at accept
    logic [`RASTER_COORD_W-1:0] x0_q;
    logic [`RASTER_COORD_W-1:0] x1_q;
    logic [`RASTER_COORD_W-1:0] y1_q;
    logic [`RASTER_DEPTH_W-1:0] depth_q;
    logic [`RASTER_COLOR_W-1:0] color_q;

    logic obj_fire;
    logic frag_fire;
    logic row_end;
    logic last_frag;

    // take a new rectangle only when idle
    assign o_obj_ready = (state_q == RAST_IDLE);
    assign obj_fire    = i_obj_valid && o_obj_ready;

    // payload comes straight from registers, stable until transfer
    assign frag.valid = (state_q == RAST_EMIT);
    assign frag.addr  = ADDR_W'(y_q) * ADDR_W'(`RASTER_SCREEN_W) + ADDR_W'(x_q);
    assign frag.depth = depth_q;
    assign frag.color = color_q;
    assign frag_fire  = frag.valid && frag.ready;

    assign row_end   = (x_q == x1_q);
    assign last_frag = row_end && (y_q == y1_q);

    always_ff @(posedge clk_100m) begin
        if (i_rst) begin
            state_q <= RAST_IDLE;
        end else if (obj_fire) begin
            state_q <= RAST_EMIT;
        end else if (frag_fire && last_frag) begin
            // bottom-right corner transferred
            state_q <= RAST_IDLE;
        end
    end

    // scan position and payload
    always_ff @(posedge clk_100m) begin
        if (obj_fire) begin
            x_q     <= i_obj.x0;
            y_q     <= i_obj.y0;
            x0_q    <= i_obj.x0;
            x1_q    <= i_obj.x1;
            y1_q    <= i_obj.y1;
            depth_q <= i_obj.depth;
            color_q <= i_obj.color;
        end else if (frag_fire) begin
            // x first, then wrap to next row
            if (row_end) begin
                x_q <= x0_q;
                y_q <= y_q + `RASTER_COORD_W'(1);
            end else begin
                x_q <= x_q + `RASTER_COORD_W'(1);
            end
        end
    end

endmodule

//--- rtl/frame_ctrl.sv
`timescale 1ns/1ps
`include "raster_cfg.svh"

module frame_ctrl import raster_pkg::*; (
    input  logic                       clk_100m,
    input  logic                       i_rst,
    input  logic                       i_frame_start,
    input  logic [`RASTER_COUNT_W-1:0] i_num_objects,
    input  logic                       i_obj_valid,
    input  rect_obj_t                  i_obj,
    input  logic                       i_raster_ready,
    input  logic                       i_clear_done,
    output logic                       o_obj_ready,
    output logic                       o_raster_valid,
    output rect_obj_t                  o_raster_obj,
    output logic                       o_clear_start,
    output logic                       o_frame_done,
    output logic                       o_busy
);

    frame_state_t state_q;
    frame_state_t state_d;

    // frame object count and objects admitted so far
    logic [`RASTER_COUNT_W-1:0] num_objs_q;
    logic [`RASTER_COUNT_W-1:0] admitted_q;

    logic all_admitted;
    logic admit_open;
    logic obj_fire;
    logic frame_go;

    // the one count test, also catches zero-object frames
    assign all_admitted = (admitted_q == num_objs_q);

    // object handshake only in RENDER with objects left
    assign admit_open     = (state_q == RENDER) && !all_admitted;
    assign o_raster_valid = admit_open && i_obj_valid;
    assign o_obj_ready    = admit_open && i_raster_ready;
    assign o_raster_obj   = i_obj;
    assign obj_fire       = o_raster_valid && o_obj_ready;

    // start only taken while idle
    assign frame_go = (state_q == IDLE) && i_frame_start;

    assign o_frame_done = (state_q == DONE);
    assign o_busy       = (state_q == CLEAR_FB) || (state_q == RENDER);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (i_frame_start) begin
                    state_d = CLEAR_FB;
                end
            end
            CLEAR_FB: begin
                // empty frame skips render
                if (i_clear_done) begin
                    state_d = all_admitted ? DONE : RENDER;
                end
            end
            RENDER: begin
                // raster ready means the last object has drained
                if (all_admitted && i_raster_ready) begin
                    state_d = DONE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_100m) begin
        if (i_rst) begin
            state_q       <= IDLE;
            num_objs_q    <= '0;
            admitted_q    <= '0;
            o_clear_start <= 1'b0;
        end else begin
            state_q <= state_d;
            // one-cycle pulse on entry to CLEAR_FB
            o_clear_start <= frame_go;
            if (frame_go) begin
                num_objs_q <= i_num_objects;
                admitted_q <= '0;
            end else if (obj_fire) begin
                admitted_q <= admitted_q + `RASTER_COUNT_W'(1);
            end
        end
    end

endmodule

//--- common/frag_if.sv
`timescale 1ns/1ps
`include "raster_cfg.svh"

// fragment stream, raster to framebuffer
interface frag_if;

    // handshake
    logic valid;
    logic ready;

    // payload, held from valid until transfer
    logic [`RASTER_ADDR_W-1:0]  addr;
    logic [`RASTER_DEPTH_W-1:0] depth;
    logic [`RASTER_COLOR_W-1:0] color;

    // raster side
    modport producer (output valid, output addr, output depth, output color, input ready);

    // framebuffer side
    modport consumer (input valid, input addr, input depth, input color, output ready);

endinterface

//--- common/raster_pkg.sv
`include "raster_cfg.svh"

package raster_pkg;

    // frame sequencer states
    typedef enum logic [1:0] {
        IDLE,
        CLEAR_FB,
        RENDER,
        DONE
    } frame_state_t;

    // screen-space rectangle, corners inclusive
    // x0 sits in the top bits, color in the bottom bits
    typedef struct packed {
        logic [`RASTER_COORD_W-1:0] x0;
        logic [`RASTER_COORD_W-1:0] y0;
        logic [`RASTER_COORD_W-1:0] x1;
        logic [`RASTER_COORD_W-1:0] y1;
        // smaller is nearer
        logic [`RASTER_DEPTH_W-1:0] depth;
        // palette index
        logic [`RASTER_COLOR_W-1:0] color;
    } rect_obj_t;

endpackage

//--- common/raster_cfg.svh
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// screen size in pixels
`define RASTER_SCREEN_W 32'd16
`define RASTER_SCREEN_H 32'd12

// pixel address, covers all 192 pixels
`define RASTER_ADDR_W 8

// one x or y coordinate
`define RASTER_COORD_W 4

// depth and colour index widths
`define RASTER_DEPTH_W 12
`define RASTER_COLOR_W 4

// objects per frame
`define RASTER_COUNT_W 8

`endif
